// File: verilog/pers_pkg.sv
`default_nettype none

package pers_pkg;

   // ----------------------------------------
   // Widths
   // ----------------------------------------
   localparam int INST_W             = 32;
   localparam int DATA_W             = 64;
   localparam int AEG_IDX_W          = 18;
   localparam int AEG_IDX_LIMIT_BITS = 8;
   localparam int EXC_W              = 16;
   localparam int ADDR_W             = 48;
   localparam int THREAD_W           = 9;
   localparam int COUNT_W            = 32;

   // ----------------------------------------
   // Opcode fields
   // ----------------------------------------
   // Format 4 is matched on bits 28:25, the others on 28:24
   localparam logic [3:0] FMT_F4 = 4'b1101;
   localparam logic [4:0] FMT_F5 = 5'b11100;
   localparam logic [4:0] FMT_F6 = 5'b11101;
   localparam logic [4:0] FMT_F7 = 5'b11110;

   // Format 4 sub-ops, bits 24:18
   localparam logic [6:0] F4_WR_DATA_IDX = 7'h40;
   localparam logic [6:0] F4_RD_DATA_IDX = 7'h68;
   localparam logic [6:0] F4_RD_INST_IDX = 7'h70;

   // Format 5 and 6 sub-ops, bits 23:18
   localparam logic [5:0] F5_WR_A = 6'h18;
   localparam logic [5:0] F5_WR_B = 6'h20;
   localparam logic [5:0] F6_RD   = 6'h1C;

   // ----------------------------------------
   // Types
   // ----------------------------------------
   typedef enum logic [2:0] {
      OP_NONE,
      OP_AEG_WR,
      OP_AEG_RD,
      OP_CAEP,
      OP_UNIMPL
   } dec_op_e;

   typedef struct packed {
      dec_op_e                op;
      logic [AEG_IDX_W-1:0]   idx;
      logic [4:0]             caep_num;
      logic                   exc_unimpl;
      logic                   exc_bad_idx;
   } dec_t;

   // Taken from AEG 0, 1 and 2
   typedef struct packed {
      logic [ADDR_W-1:0]      base_address;
      logic [THREAD_W-1:0]    num_threads;
      logic [COUNT_W-1:0]     edge_count;
   } engine_cfg_t;

   typedef enum logic {
      ST_IDLE,
      ST_WAIT
   } disp_state_e;

endpackage

`default_nettype wire

// File: verilog/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
   input  logic [pers_pkg::INST_W-1:0]  cae_inst_i,
   input  logic [pers_pkg::DATA_W-1:0]  cae_data_i,
   input  logic                         cae_inst_vld_i,
   output pers_pkg::dec_t               dec_o
);

   pers_pkg::dec_op_e                   op_c;
   logic [pers_pkg::AEG_IDX_W-1:0]      idx_c;
   logic [pers_pkg::AEG_IDX_W-1:0]      idx_inst_hi;
   logic [pers_pkg::AEG_IDX_W-1:0]      idx_inst_split;

   // Index forms carried in the instruction word
   assign idx_inst_hi    = {6'h0, cae_inst_i[17:6]};
   assign idx_inst_split = {6'h0, cae_inst_i[17:12], cae_inst_i[5:0]};

   // ----------------------------------------
   // Format and sub-op classification
   // ----------------------------------------
   always_comb begin
      op_c  = pers_pkg::OP_UNIMPL;
      idx_c = '0;
      if (cae_inst_i[28:25] == pers_pkg::FMT_F4) begin
         case (cae_inst_i[24:18])
            pers_pkg::F4_WR_DATA_IDX: begin
               op_c  = pers_pkg::OP_AEG_WR;
               idx_c = cae_data_i[pers_pkg::AEG_IDX_W-1:0];
            end
            pers_pkg::F4_RD_DATA_IDX: begin
               op_c  = pers_pkg::OP_AEG_RD;
               idx_c = cae_data_i[pers_pkg::AEG_IDX_W-1:0];
            end
            pers_pkg::F4_RD_INST_IDX: begin
               op_c  = pers_pkg::OP_AEG_RD;
               idx_c = idx_inst_hi;
            end
            default: begin
               op_c = pers_pkg::OP_UNIMPL;
            end
         endcase
      end else if (cae_inst_i[28:24] == pers_pkg::FMT_F5) begin
         if (cae_inst_i[23:18] == pers_pkg::F5_WR_A ||
             cae_inst_i[23:18] == pers_pkg::F5_WR_B) begin
            op_c  = pers_pkg::OP_AEG_WR;
            idx_c = idx_inst_split;
         end
      end else if (cae_inst_i[28:24] == pers_pkg::FMT_F6) begin
         if (cae_inst_i[23:18] == pers_pkg::F6_RD) begin
            op_c  = pers_pkg::OP_AEG_RD;
            idx_c = idx_inst_hi;
         end
      end else if (cae_inst_i[28:24] == pers_pkg::FMT_F7) begin
         // Only the upper CAEP range is implemented
         if (cae_inst_i[23]) begin
            op_c = pers_pkg::OP_CAEP;
         end
      end
   end

   // ----------------------------------------
   // Outputs, qualified by the strobe
   // ----------------------------------------
   always_comb begin
      dec_o.op          = cae_inst_vld_i ? op_c : pers_pkg::OP_NONE;
      dec_o.idx         = idx_c;
      dec_o.caep_num    = cae_inst_i[22:18];
      dec_o.exc_unimpl  = cae_inst_vld_i && (op_c == pers_pkg::OP_UNIMPL);
      // Any index bit above the allowed range is an error
      dec_o.exc_bad_idx = cae_inst_vld_i &&
                          (|idx_c[pers_pkg::AEG_IDX_W-1:pers_pkg::AEG_IDX_LIMIT_BITS]);
   end

endmodule

`default_nettype wire

// File: verilog/aeg_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module aeg_regfile #(
   parameter int NUM_AEG = 3
) (
   input  logic                         clk_per,
   input  logic                         reset_per,
   input  pers_pkg::dec_t               dec_i,
   input  logic [pers_pkg::DATA_W-1:0]  cae_data_i,
   input  logic                         stall_i,
   output logic [pers_pkg::DATA_W-1:0]  ret_data_o,
   output logic                         ret_vld_o,
   output pers_pkg::engine_cfg_t        engine_cfg_o
);

   logic                                wr_q;
   logic                                rd_q;
   logic [pers_pkg::AEG_IDX_W-1:0]      idx_q;
   logic [pers_pkg::DATA_W-1:0]         data_q;
   logic [pers_pkg::DATA_W-1:0]         aeg_q [NUM_AEG];
   logic [pers_pkg::DATA_W-1:0]         rd_data_c;
   logic [pers_pkg::DATA_W-1:0]         ret_data_q;
   logic                                ret_vld_q;

   // ----------------------------------------
   // Request stage
   // ----------------------------------------
   always_ff @(posedge clk_per) begin
      if (reset_per) begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end else begin
         wr_q <= (dec_i.op == pers_pkg::OP_AEG_WR);
         rd_q <= (dec_i.op == pers_pkg::OP_AEG_RD);
      end
   end

   always_ff @(posedge clk_per) begin
      idx_q  <= dec_i.idx;
      data_q <= cae_data_i;
   end

   // ----------------------------------------
   // Register update and read select
   // ----------------------------------------
   // Indices past the last AEG match no entry
   always_ff @(posedge clk_per) begin
      for (int i = 0; i < NUM_AEG; i++) begin
         if (wr_q && (idx_q == pers_pkg::AEG_IDX_W'(i))) begin
            aeg_q[i] <= data_q;
         end
      end
   end

   always_comb begin
      rd_data_c = '0;
      for (int i = 0; i < NUM_AEG; i++) begin
         if (idx_q == pers_pkg::AEG_IDX_W'(i)) begin
            rd_data_c = aeg_q[i];
         end
      end
   end

   // Return stage
   always_ff @(posedge clk_per) begin
      if (reset_per) begin
         ret_vld_q <= 1'b0;
      end else begin
         ret_vld_q <= rd_q;
      end
   end

   always_ff @(posedge clk_per) begin
      ret_data_q <= rd_data_c;
   end

   // A return that meets a stall is dropped
   assign ret_vld_o  = ret_vld_q && !stall_i;
   assign ret_data_o = ret_data_q;

   assign engine_cfg_o.base_address = aeg_q[0][pers_pkg::ADDR_W-1:0];
   assign engine_cfg_o.num_threads  = aeg_q[1][pers_pkg::THREAD_W-1:0];
   assign engine_cfg_o.edge_count   = aeg_q[2][pers_pkg::COUNT_W-1:0];

endmodule

`default_nettype wire

// File: verilog/dispatch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_ctrl (
   input  logic            clk_per,
   input  logic            reset_per,
   input  pers_pkg::dec_t  dec_i,
   input  logic            intlv_dis_i,
   input  logic            engine_idle_i,
   output logic            stall_o,
   output logic            idle_o,
   output logic            engine_start_o
);

   logic                   caep00_c;
   logic                   start_q;
   pers_pkg::disp_state_e  state_q;
   pers_pkg::disp_state_e  state_d;

   // CAEP00 only launches with interleave disabled
   assign caep00_c = (dec_i.op == pers_pkg::OP_CAEP) &&
                     (dec_i.caep_num == 5'd0) && intlv_dis_i;

   always_ff @(posedge clk_per) begin
      if (reset_per) begin
         start_q <= 1'b0;
      end else begin
         start_q <= caep00_c;
      end
   end

   // ----------------------------------------
   // IDLE/WAIT FSM
   // ----------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         pers_pkg::ST_IDLE: begin
            if (start_q) begin
               state_d = pers_pkg::ST_WAIT;
            end
         end
         pers_pkg::ST_WAIT: begin
            // Hold until the engine reports done
            if (engine_idle_i) begin
               state_d = pers_pkg::ST_IDLE;
            end
         end
         default: begin
            state_d = pers_pkg::ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_per) begin
      if (reset_per) begin
         state_q <= pers_pkg::ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Stall covers the launch cycle, the start pulse and the whole wait
   assign stall_o        = caep00_c || start_q || (state_q == pers_pkg::ST_WAIT);
   assign idle_o         = !stall_o;
   assign engine_start_o = start_q;

endmodule

`default_nettype wire

// File: verilog/pers_core.sv
`timescale 1ns/100ps
`default_nettype none

module pers_core #(
   parameter int NUM_AEG = 3
) (
   input  logic                         clk_per,
   input  logic                         reset_per,

   // Dispatch port
   input  logic [pers_pkg::INST_W-1:0]  cae_inst_i,
   input  logic [pers_pkg::DATA_W-1:0]  cae_data_i,
   input  logic                         cae_inst_vld_i,
   output logic [pers_pkg::DATA_W-1:0]  cae_ret_data_o,
   output logic                         cae_ret_data_vld_o,
   output logic [pers_pkg::EXC_W-1:0]   cae_exception_o,
   output logic                         cae_stall_o,
   output logic                         cae_idle_o,

   input  logic                         intlv_dis_i,

   // Engine side
   input  logic                         engine_idle_i,
   output logic                         engine_start_o,
   output pers_pkg::engine_cfg_t        engine_cfg_o
);

   pers_pkg::dec_t                      dec;
   logic                                stall;

   inst_decode u_inst_decode (
      .cae_inst_i     (cae_inst_i),
      .cae_data_i     (cae_data_i),
      .cae_inst_vld_i (cae_inst_vld_i),
      .dec_o          (dec)
   );

   aeg_regfile #(
      .NUM_AEG (NUM_AEG)
   ) u_aeg_regfile (
      .clk_per      (clk_per),
      .reset_per    (reset_per),
      .dec_i        (dec),
      .cae_data_i   (cae_data_i),
      .stall_i      (stall),
      .ret_data_o   (cae_ret_data_o),
      .ret_vld_o    (cae_ret_data_vld_o),
      .engine_cfg_o (engine_cfg_o)
   );

   dispatch_ctrl u_dispatch_ctrl (
      .clk_per        (clk_per),
      .reset_per      (reset_per),
      .dec_i          (dec),
      .intlv_dis_i    (intlv_dis_i),
      .engine_idle_i  (engine_idle_i),
      .stall_o        (stall),
      .idle_o         (cae_idle_o),
      .engine_start_o (engine_start_o)
   );

   assign cae_stall_o = stall;

   // Bit 0 unimplemented, bit 1 invalid index
   assign cae_exception_o = {{(pers_pkg::EXC_W-2){1'b0}}, dec.exc_bad_idx, dec.exc_unimpl};

endmodule

`default_nettype wire

// File: sim/pers_core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module pers_core_properties (
   input logic                        clk_per,
   input logic                        reset_per,
   input logic                        start_i,
   input logic                        stall_i,
   input logic                        idle_i,
   input logic                        ret_vld_i,
   input logic [pers_pkg::EXC_W-1:0]  exception_i
);

   int fail_cnt = 0;

   // Start is a single-cycle pulse
   start_pulse_a: assert property (@(posedge clk_per) disable iff (reset_per)
      start_i |=> !start_i)
   else begin
      $error("engine start high in two consecutive cycles");
      fail_cnt++;
   end

   idle_inverse_a: assert property (@(posedge clk_per) disable iff (reset_per)
      idle_i == !stall_i)
   else begin
      $error("idle is not the inverse of stall");
      fail_cnt++;
   end

   // Returns that meet a stall are dropped
   no_ret_in_stall_a: assert property (@(posedge clk_per) disable iff (reset_per)
      stall_i |-> !ret_vld_i)
   else begin
      $error("return valid while stalled");
      fail_cnt++;
   end

   exc_upper_zero_a: assert property (@(posedge clk_per) disable iff (reset_per)
      exception_i[pers_pkg::EXC_W-1:2] == '0)
   else begin
      $error("exception bits above bit 1 set");
      fail_cnt++;
   end

endmodule

bind pers_core pers_core_properties props_i (
   .clk_per     (clk_per),
   .reset_per   (reset_per),
   .start_i     (engine_start_o),
   .stall_i     (cae_stall_o),
   .idle_i      (cae_idle_o),
   .ret_vld_i   (cae_ret_data_vld_o),
   .exception_i (cae_exception_o)
);

`default_nettype wire

// File: sim/pers_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pers_core_tb;

   // The five tests take under 100 cycles after reset
   localparam int TIMEOUT_CYCLES = 2000;

   typedef struct packed {
      logic [31:0]  due;
      logic [63:0]  data;
   } ret_exp_t;

   logic                          clk_per;
   logic                          reset_per;
   logic [31:0]                   cae_inst_i;
   logic [63:0]                   cae_data_i;
   logic                          cae_inst_vld_i;
   logic                          intlv_dis_i;
   logic                          engine_idle_i;
   logic [63:0]                   cae_ret_data_o;
   logic                          cae_ret_data_vld_o;
   logic [pers_pkg::EXC_W-1:0]    cae_exception_o;
   logic                          cae_stall_o;
   logic                          cae_idle_o;
   logic                          engine_start_o;
   pers_pkg::engine_cfg_t         engine_cfg_o;

   int                            cyc = 0;
   int                            checks = 0;
   int                            errors = 0;
   int                            ret_errors = 0;
   int                            start_cnt = 0;
   int                            start_mark;
   int                            err_mark = 0;
   int                            busy_len = 3;
   int                            total;
   integer                        seed;
   logic [63:0]                   aeg_model [3];
   ret_exp_t                      ret_q [$];
   ret_exp_t                      ret_head;

   pers_core #(
      .NUM_AEG (3)
   ) dut_i (
      .clk_per            (clk_per),
      .reset_per          (reset_per),
      .cae_inst_i         (cae_inst_i),
      .cae_data_i         (cae_data_i),
      .cae_inst_vld_i     (cae_inst_vld_i),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o),
      .cae_exception_o    (cae_exception_o),
      .cae_stall_o        (cae_stall_o),
      .cae_idle_o         (cae_idle_o),
      .intlv_dis_i        (intlv_dis_i),
      .engine_idle_i      (engine_idle_i),
      .engine_start_o     (engine_start_o),
      .engine_cfg_o       (engine_cfg_o)
   );

   initial begin
      clk_per = 1'b0;
      forever #10 clk_per = ~clk_per;
   end

   initial begin
      while (cyc < TIMEOUT_CYCLES) begin
         @(posedge clk_per);
         cyc++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // ----------------------------------------
   // Engine model
   // ----------------------------------------
   initial begin
      engine_idle_i = 1'b1;
      forever begin
         @(posedge clk_per);
         if (engine_start_o) begin
            #2;
            engine_idle_i = 1'b0;
            repeat (busy_len) @(posedge clk_per);
            #2;
            engine_idle_i = 1'b1;
         end
      end
   end

   always @(posedge clk_per) begin
      if (engine_start_o) begin
         start_cnt <= start_cnt + 1;
      end
   end

   // Return checker with one expected entry per read
   always @(negedge clk_per) begin
      if (!reset_per && ret_q.size() != 0 && ret_q[0].due == cyc) begin
         ret_head = ret_q.pop_front();
         assert (cae_ret_data_vld_o && cae_ret_data_o === ret_head.data) else begin
            $display("ERR %0t cae_ret_data_o expected %h got %h (valid %b)",
                     $time, ret_head.data, cae_ret_data_o, cae_ret_data_vld_o);
            ret_errors++;
         end
      end else if (!reset_per) begin
         assert (!cae_ret_data_vld_o) else begin
            $display("Return valid at %0t with no read outstanding", $time);
            ret_errors++;
         end
      end
   end

   // ----------------------------------------
   // Encoders and checks
   // ----------------------------------------
   function automatic logic [31:0] enc_f4(input logic [6:0] sub, input logic [11:0] fld);
      enc_f4 = {3'b000, pers_pkg::FMT_F4, sub, fld, 6'h00};
   endfunction

   function automatic logic [31:0] enc_f5(input logic [5:0] sub, input logic [11:0] idx);
      enc_f5 = {3'b000, pers_pkg::FMT_F5, sub, idx[11:6], 6'h00, idx[5:0]};
   endfunction

   function automatic logic [31:0] enc_f6(input logic [11:0] idx);
      enc_f6 = {3'b000, pers_pkg::FMT_F6, pers_pkg::F6_RD, idx, 6'h00};
   endfunction

   function automatic logic [31:0] enc_caep(input logic hi, input logic [4:0] num);
      enc_caep = {3'b000, pers_pkg::FMT_F7, hi, num, 18'h0};
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
         errors++;
      end
   endtask

   // One strobe with exception and stall checked in its cycle
   task automatic dispatch(input logic [31:0] inst, input logic [63:0] data, input logic rd,
                           input logic [63:0] rd_exp, input logic [15:0] exc_exp,
                           input logic stall_exp);
      @(posedge clk_per);
      #2;
      cae_inst_i     = inst;
      cae_data_i     = data;
      cae_inst_vld_i = 1'b1;
      if (rd) begin
         ret_q.push_back({32'(cyc + 2), rd_exp});
      end
      @(negedge clk_per);
      check_val("cae_exception_o", 64'(cae_exception_o), 64'(exc_exp));
      check_bit("cae_stall_o", cae_stall_o, stall_exp);
      @(posedge clk_per);
      #2;
      cae_inst_vld_i = 1'b0;
   endtask

   task automatic drain_reads;
      while (ret_q.size() != 0) begin
         @(negedge clk_per);
      end
      @(negedge clk_per);
   endtask

   task automatic end_test(input string name);
      $display("%s done, %0d errors", name, errors + ret_errors - err_mark);
      err_mark = errors + ret_errors;
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      seed           = 32'h7cde;
      reset_per      = 1'b1;
      cae_inst_i     = '0;
      cae_data_i     = '0;
      cae_inst_vld_i = 1'b0;
      intlv_dis_i    = 1'b1;
      repeat (16) @(posedge clk_per);
      #2;
      reset_per = 1'b0;
      @(negedge clk_per);
      check_bit("cae_idle_o", cae_idle_o, 1'b1);
      check_bit("engine_start_o", engine_start_o, 1'b0);

      for (int i = 0; i < 3; i++) begin
         aeg_model[i] = {$random(seed), $random(seed)};
      end
      // Format 4 write takes its index from the data
      aeg_model[0][17:0] = '0;
      busy_len = 3 + ($random(seed) & 7);

      // Instruction and data index fields differ so the wrong source hits another AEG
      dispatch(enc_f4(pers_pkg::F4_WR_DATA_IDX, 12'd2), aeg_model[0], 1'b0, '0, 16'h0, 1'b0);
      dispatch(enc_f5(pers_pkg::F5_WR_A, 12'd1), aeg_model[1], 1'b0, '0, 16'h0, 1'b0);
      dispatch(enc_f5(pers_pkg::F5_WR_B, 12'd2), aeg_model[2], 1'b0, '0, 16'h0, 1'b0);
      repeat (2) @(posedge clk_per);
      dispatch(enc_f4(pers_pkg::F4_RD_INST_IDX, 12'd0), 64'd1, 1'b1, aeg_model[0], 16'h0,
               1'b0);
      dispatch(enc_f6(12'd1), '0, 1'b1, aeg_model[1], 16'h0, 1'b0);
      dispatch(enc_f4(pers_pkg::F4_RD_DATA_IDX, 12'd0), 64'd2, 1'b1, aeg_model[2], 16'h0, 1'b0);
      drain_reads();
      end_test("Test 1 write and read back");

      check_val("engine_cfg_o.base_address", 64'(engine_cfg_o.base_address),
                64'(aeg_model[0][47:0]));
      check_val("engine_cfg_o.num_threads", 64'(engine_cfg_o.num_threads),
                64'(aeg_model[1][8:0]));
      check_val("engine_cfg_o.edge_count", 64'(engine_cfg_o.edge_count),
                64'(aeg_model[2][31:0]));
      end_test("Test 2 engine configuration");

      dispatch(enc_f4(pers_pkg::F4_WR_DATA_IDX, 12'd0), 64'h200, 1'b0, '0, 16'h2, 1'b0);
      dispatch(enc_f4(7'h11, 12'd0), '0, 1'b0, '0, 16'h1, 1'b0);
      dispatch(enc_caep(1'b0, 5'd0), '0, 1'b0, '0, 16'h1, 1'b0);
      dispatch(enc_f6(12'd5), '0, 1'b1, 64'h0, 16'h0, 1'b0);
      drain_reads();
      end_test("Test 3 exceptions");

      start_mark = start_cnt;
      dispatch(enc_caep(1'b1, 5'd0), '0, 1'b0, '0, 16'h0, 1'b1);
      @(negedge clk_per);
      check_bit("engine_start_o", engine_start_o, 1'b1);
      check_bit("cae_stall_o", cae_stall_o, 1'b1);
      @(negedge clk_per);
      while (!engine_idle_i) begin
         check_bit("cae_stall_o", cae_stall_o, 1'b1);
         @(negedge clk_per);
      end
      // Stall drops one cycle after idle is seen in WAIT
      check_bit("cae_stall_o", cae_stall_o, 1'b1);
      @(negedge clk_per);
      check_bit("cae_stall_o", cae_stall_o, 1'b0);
      check_bit("cae_idle_o", cae_idle_o, 1'b1);
      check_val("engine start count", 64'(start_cnt), 64'(start_mark + 1));
      end_test("Test 4 CAEP00 launch");

      start_mark = start_cnt;
      @(posedge clk_per);
      #2;
      intlv_dis_i = 1'b0;
      dispatch(enc_caep(1'b1, 5'd0), '0, 1'b0, '0, 16'h0, 1'b0);
      repeat (4) begin
         @(negedge clk_per);
         check_bit("cae_stall_o", cae_stall_o, 1'b0);
      end
      @(posedge clk_per);
      #2;
      intlv_dis_i = 1'b1;
      dispatch(enc_caep(1'b1, 5'd3), '0, 1'b0, '0, 16'h0, 1'b0);
      repeat (4) begin
         @(negedge clk_per);
         check_bit("cae_stall_o", cae_stall_o, 1'b0);
      end
      check_val("engine start count", 64'(start_cnt), 64'(start_mark));
      end_test("Test 5 ignored CAEP");

      total = errors + ret_errors + dut_i.props_i.fail_cnt;
      $display("Checks: %0d, errors: %0d, property failures: %0d",
               checks, errors + ret_errors, dut_i.props_i.fail_cnt);
      if (total == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
verilog/pers_pkg.sv
verilog/inst_decode.sv
verilog/aeg_regfile.sv
verilog/dispatch_ctrl.sv
verilog/pers_core.sv
sim/pers_core_properties.sv
sim/pers_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pers_core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f files.f --top-module pers_core_tb -Mdir "$BUILD_DIR" -o pers_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/pers_core_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
